/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int XLEN = 64;                   // One register word

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     word_t;            // Low half seen by the W ops
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [5:0]      shamt_t;           // RV64 shifts take 6 bits

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP        = 7'b0110011,
        OPC_OP_32     = 7'b0111011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_PASS_B                              // LUI
    } alu_op_e;

    // Branch condition is funct3 as is
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_e;

    localparam instr_t NOP_INSTR = 32'h0000_0013;   // addi x0, x0, 0

    typedef struct packed {
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    rd;
        xlen_t       imm;
        alu_op_e     alu_op;
        logic        word;      // 32-bit op, result sign-extended
        logic        imm_b;     // Operand B is the immediate
        logic        pc_a;      // Operand A is the exec PC
        logic        jump;
        logic        jalr;
        logic        branch;
        logic        load;
        logic        store;
        logic [2:0]  funct3;
        logic        wb_en;
    } decoded_t;

endpackage

/* hdl/rv_bus_pkg.sv */
package rv_bus_pkg;

    typedef logic [63:0] addr_t;

    // Load/store funct3, also the access size on the bus
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_size_e;

    typedef struct packed {
        addr_t             addr;
        rv_isa_pkg::xlen_t wdata;   // Right-justified, zero above size
        logic              rd;      // One-cycle read strobe
        logic              wr;      // One-cycle write strobe
        ls_size_e          size;
    } bus_req_t;

    localparam addr_t RAM_BASE = 64'h8000_0000;     // Reset PC

endpackage

/* hdl/rv_decoder.sv */
module rv_decoder (
    input  rv_isa_pkg::instr_t   instr_i,
    output rv_isa_pkg::decoded_t dec_o
);
    rv_isa_pkg::opcode_e opcode;
    rv_isa_pkg::xlen_t   imm_i;
    rv_isa_pkg::xlen_t   imm_s;
    rv_isa_pkg::xlen_t   imm_b;
    rv_isa_pkg::xlen_t   imm_u;
    rv_isa_pkg::xlen_t   imm_j;

    // funct3 to ALU op, alt is funct7 bit 5 where it counts
    function automatic rv_isa_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        rv_isa_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            3'b001:  op = rv_isa_pkg::ALU_SLL;
            3'b010:  op = rv_isa_pkg::ALU_SLT;
            3'b011:  op = rv_isa_pkg::ALU_SLTU;
            3'b100:  op = rv_isa_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            3'b110:  op = rv_isa_pkg::ALU_OR;
            default: op = rv_isa_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = rv_isa_pkg::opcode_e'(instr_i[6:0]);
    assign imm_i  = {{52{instr_i[31]}}, instr_i[31:20]};
    assign imm_s  = {{52{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b  = {{52{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u  = {{32{instr_i[31]}}, instr_i[31:12], 12'd0};
    assign imm_j  = {{44{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        dec_o        = '0;              // Unknown opcode does nothing
        dec_o.rs1    = instr_i[19:15];
        dec_o.rs2    = instr_i[24:20];
        dec_o.rd     = instr_i[11:7];
        dec_o.funct3 = instr_i[14:12];
        dec_o.imm    = imm_i;
        dec_o.alu_op = rv_isa_pkg::ALU_ADD;
        case (opcode)
            rv_isa_pkg::OPC_LUI: begin
                {dec_o.imm, dec_o.alu_op} = {imm_u, rv_isa_pkg::ALU_PASS_B};
                {dec_o.imm_b, dec_o.wb_en} = 2'b11;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                dec_o.imm = imm_u;
                {dec_o.pc_a, dec_o.imm_b, dec_o.wb_en} = 3'b111;
            end
            rv_isa_pkg::OPC_JAL: begin
                dec_o.imm = imm_j;      // ALU forms the target
                {dec_o.pc_a, dec_o.imm_b, dec_o.jump, dec_o.wb_en} = 4'b1111;
            end
            rv_isa_pkg::OPC_JALR:   {dec_o.imm_b, dec_o.jalr, dec_o.wb_en} = 3'b111;
            rv_isa_pkg::OPC_BRANCH: begin
                dec_o.imm    = imm_b;   // rs1 vs rs2 in the ALU
                dec_o.branch = 1'b1;
            end
            rv_isa_pkg::OPC_LOAD:   {dec_o.imm_b, dec_o.load, dec_o.wb_en} = 3'b111;
            rv_isa_pkg::OPC_STORE: begin
                dec_o.imm = imm_s;
                {dec_o.imm_b, dec_o.store} = 2'b11;
            end
            rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP_IMM_32: begin
                // Only srai uses bit 30, addi must not become sub
                dec_o.alu_op = arith_op(instr_i[14:12], instr_i[30] && instr_i[14:12] == 3'b101);
                dec_o.word   = (opcode == rv_isa_pkg::OPC_OP_IMM_32);
                {dec_o.imm_b, dec_o.wb_en} = 2'b11;
            end
            rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_32: begin
                dec_o.alu_op = arith_op(instr_i[14:12], instr_i[30]);
                dec_o.word   = (opcode == rv_isa_pkg::OPC_OP_32);
                dec_o.wb_en  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/rv_alu.sv */
module rv_alu (
    input  rv_isa_pkg::xlen_t   a_i,
    input  rv_isa_pkg::xlen_t   b_i,
    input  rv_isa_pkg::alu_op_e op_i,
    input  logic                word_i,
    input  rv_isa_pkg::branch_e branch_i,
    output rv_isa_pkg::xlen_t   result_o,
    output logic                taken_o
);
    rv_isa_pkg::shamt_t sh_d;       // 64-bit shift amount
    rv_isa_pkg::word_t  a_w;
    rv_isa_pkg::word_t  b_w;
    rv_isa_pkg::word_t  res_w;
    rv_isa_pkg::xlen_t  res_d;

    assign sh_d = b_i[5:0];
    assign a_w  = a_i[31:0];
    assign b_w  = b_i[31:0];

    // Full width result
    always_comb begin
        case (op_i)
            rv_isa_pkg::ALU_ADD:  res_d = a_i + b_i;
            rv_isa_pkg::ALU_SUB:  res_d = a_i - b_i;
            rv_isa_pkg::ALU_XOR:  res_d = a_i ^ b_i;
            rv_isa_pkg::ALU_OR:   res_d = a_i | b_i;
            rv_isa_pkg::ALU_AND:  res_d = a_i & b_i;
            rv_isa_pkg::ALU_SLL:  res_d = a_i << sh_d;
            rv_isa_pkg::ALU_SRL:  res_d = a_i >> sh_d;
            rv_isa_pkg::ALU_SRA:  res_d = $signed(a_i) >>> sh_d;
            rv_isa_pkg::ALU_SLT:  res_d = {63'd0, $signed(a_i) < $signed(b_i)};
            rv_isa_pkg::ALU_SLTU: res_d = {63'd0, a_i < b_i};
            default:              res_d = b_i;  // Pass B
        endcase
    end

    // Word form, shifts use only 5 bits
    always_comb begin
        case (op_i)
            rv_isa_pkg::ALU_ADD: res_w = a_w + b_w;
            rv_isa_pkg::ALU_SUB: res_w = a_w - b_w;
            rv_isa_pkg::ALU_SLL: res_w = a_w << b_w[4:0];
            rv_isa_pkg::ALU_SRL: res_w = a_w >> b_w[4:0];
            rv_isa_pkg::ALU_SRA: res_w = $signed(a_w) >>> b_w[4:0];
            default:             res_w = res_d[31:0];
        endcase
    end

    assign result_o = word_i ? {{32{res_w[31]}}, res_w} : res_d;   // W ops sign-extend

    // Branch compare on rs1, rs2
    always_comb begin
        case (branch_i)
            rv_isa_pkg::BR_EQ:  taken_o = (a_i == b_i);
            rv_isa_pkg::BR_NE:  taken_o = (a_i != b_i);
            rv_isa_pkg::BR_LT:  taken_o = ($signed(a_i) < $signed(b_i));
            rv_isa_pkg::BR_GE:  taken_o = ($signed(a_i) >= $signed(b_i));
            rv_isa_pkg::BR_LTU: taken_o = (a_i < b_i);
            rv_isa_pkg::BR_GEU: taken_o = (a_i >= b_i);
            default:            taken_o = 1'b0;     // 010, 011 not branches
        endcase
    end

endmodule

/* hdl/rv_regfile.sv */
module rv_regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_isa_pkg::reg_idx_t rs1_i,
    input  rv_isa_pkg::reg_idx_t rs2_i,
    output rv_isa_pkg::xlen_t    rs1_data_o,
    output rv_isa_pkg::xlen_t    rs2_data_o,
    input  logic                 we_i,
    input  rv_isa_pkg::reg_idx_t rd_i,
    input  rv_isa_pkg::xlen_t    rd_data_i
);
    rv_isa_pkg::xlen_t regs [32];

    // Async read
    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin     // x0 writes dropped
            regs[rd_i] <= rd_data_i;
        end
    end

    // x0 reads zero whatever the core tries to write
    a_x0_zero: assert property (@(posedge clk) disable iff (!reset)
        regs[0] == '0);

endmodule

/* hdl/rv_exec_ctrl.sv */
module rv_exec_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_isa_pkg::instr_t   instr_i,
    output rv_bus_pkg::addr_t    pc_o,
    output rv_isa_pkg::instr_t   ir_o,
    input  rv_isa_pkg::decoded_t dec_i,
    input  rv_isa_pkg::xlen_t    rs1_data_i,
    input  rv_isa_pkg::xlen_t    rs2_data_i,
    input  rv_isa_pkg::xlen_t    alu_result_i,
    input  logic                 taken_i,
    output logic                 we_o,
    output rv_isa_pkg::reg_idx_t rd_o,
    output rv_isa_pkg::xlen_t    rd_data_o,
    output rv_bus_pkg::bus_req_t bus_req_o,
    input  logic                 rd_done_i,
    input  logic                 wr_done_i,
    input  rv_isa_pkg::xlen_t    rd_data_i
);
    typedef enum logic {
        IDLE,                           // Executing from ir_q
        WAIT                            // Bus access outstanding
    } mem_state_e;

    mem_state_e           state_q;
    rv_bus_pkg::addr_t    pc_q;         // Address being fetched
    rv_bus_pkg::addr_t    exec_pc;
    rv_bus_pkg::addr_t    next_pc;
    rv_isa_pkg::instr_t   ir_q;
    rv_bus_pkg::bus_req_t bus_req_q;
    rv_isa_pkg::reg_idx_t ld_rd_q;      // Load target, ir_q moves on during WAIT
    rv_isa_pkg::xlen_t    st_data;
    rv_isa_pkg::xlen_t    ld_data;
    logic                 bubble_q;
    logic                 exec_valid;
    logic                 redirect;

    assign pc_o       = pc_q;
    assign ir_o       = ir_q;
    assign bus_req_o  = bus_req_q;
    assign exec_pc    = pc_q - 64'd4;
    assign exec_valid = !bubble_q && (state_q == IDLE);
    assign redirect   = dec_i.jump || dec_i.jalr || (dec_i.branch && taken_i);

    always_comb begin
        if (dec_i.jalr) begin
            next_pc = (rs1_data_i + dec_i.imm) & ~64'd1;
        end else if (dec_i.jump) begin
            next_pc = alu_result_i;     // exec_pc + J imm
        end else begin
            next_pc = exec_pc + dec_i.imm;
        end
    end

    // Store data truncated to size
    always_comb begin
        case (dec_i.funct3[1:0])
            2'd0:    st_data = {56'd0, rs2_data_i[7:0]};
            2'd1:    st_data = {48'd0, rs2_data_i[15:0]};
            2'd2:    st_data = {32'd0, rs2_data_i[31:0]};
            default: st_data = rs2_data_i;
        endcase
    end

    // Sign or zero extend by the size still on the bus
    always_comb begin
        case (bus_req_q.size)
            rv_bus_pkg::LS_B:  ld_data = {{56{rd_data_i[7]}}, rd_data_i[7:0]};
            rv_bus_pkg::LS_H:  ld_data = {{48{rd_data_i[15]}}, rd_data_i[15:0]};
            rv_bus_pkg::LS_W:  ld_data = {{32{rd_data_i[31]}}, rd_data_i[31:0]};
            rv_bus_pkg::LS_BU: ld_data = {56'd0, rd_data_i[7:0]};
            rv_bus_pkg::LS_HU: ld_data = {48'd0, rd_data_i[15:0]};
            rv_bus_pkg::LS_WU: ld_data = {32'd0, rd_data_i[31:0]};
            default:           ld_data = rd_data_i;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir_q <= rv_isa_pkg::NOP_INSTR;
        end else begin
            ir_q <= instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid && dec_i.load) begin
            ld_rd_q <= dec_i.rd;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q      <= rv_bus_pkg::RAM_BASE;
            bubble_q  <= 1'b0;
            state_q   <= IDLE;
            bus_req_q <= '0;
        end else begin
            bus_req_q.rd <= 1'b0;       // Strobes last one cycle
            bus_req_q.wr <= 1'b0;
            if (state_q == WAIT) begin
                bubble_q <= 1'b1;       // PC held, one more kill after done
                if (rd_done_i || wr_done_i) begin
                    state_q <= IDLE;
                end
            end else if (bubble_q) begin
                bubble_q <= 1'b0;
                pc_q     <= pc_q + 64'd4;
            end else if (dec_i.load || dec_i.store) begin
                bus_req_q.addr  <= alu_result_i;    // rs1 + imm
                bus_req_q.wdata <= st_data;
                bus_req_q.rd    <= dec_i.load;
                bus_req_q.wr    <= dec_i.store;
                bus_req_q.size  <= rv_bus_pkg::ls_size_e'(dec_i.funct3);
                bubble_q        <= 1'b1;
                state_q         <= WAIT;
            end else if (redirect) begin
                pc_q     <= next_pc;
                bubble_q <= 1'b1;       // Kill the wrong-path fetch
            end else begin
                pc_q <= pc_q + 64'd4;
            end
        end
    end

    // Only writer of the register file
    always_comb begin
        we_o      = 1'b0;
        rd_o      = dec_i.rd;
        rd_data_o = alu_result_i;
        if (state_q == WAIT) begin
            we_o      = rd_done_i;      // Load retires on done
            rd_o      = ld_rd_q;
            rd_data_o = ld_data;
        end else if (exec_valid && dec_i.wb_en && !dec_i.load) begin
            we_o = 1'b1;
            if (dec_i.jump || dec_i.jalr) begin
                rd_data_o = pc_q;       // Link = exec_pc + 4
            end
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!reset)
        !(bus_req_q.rd && bus_req_q.wr));

    // One access outstanding at a time
    a_no_strobe_in_wait: assert property (@(posedge clk) disable iff (!reset)
        state_q == WAIT |=> !(bus_req_q.rd || bus_req_q.wr));

    a_pc_hold: assert property (@(posedge clk) disable iff (!reset)
        state_q == WAIT |-> $stable(pc_q));

endmodule

/* hdl/rv64_core.sv */
module rv64_core (
    input  logic                 clk,
    input  logic                 reset,
    output rv_bus_pkg::addr_t    pc_o,
    input  rv_isa_pkg::instr_t   instr_i,
    output rv_bus_pkg::bus_req_t bus_req_o,
    input  logic                 rd_done_i,
    input  logic                 wr_done_i,
    input  rv_isa_pkg::xlen_t    rd_data_i
);
    rv_isa_pkg::instr_t   ir;
    rv_isa_pkg::decoded_t dec;
    rv_isa_pkg::xlen_t    rs1_data;
    rv_isa_pkg::xlen_t    rs2_data;
    rv_isa_pkg::xlen_t    alu_a;
    rv_isa_pkg::xlen_t    alu_b;
    rv_isa_pkg::xlen_t    alu_result;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::xlen_t    rd_data;
    logic                 taken;
    logic                 we;

    // Operand A is the exec PC for AUIPC and JAL
    assign alu_a = dec.pc_a ? (pc_o - 64'd4) : rs1_data;
    assign alu_b = dec.imm_b ? dec.imm : rs2_data;

    rv_exec_ctrl rv_exec_ctrl_inst (
        .clk, .reset, .instr_i, .pc_o, .ir_o(ir), .dec_i(dec),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .alu_result_i(alu_result),
        .taken_i(taken), .we_o(we), .rd_o(rd), .rd_data_o(rd_data),
        .bus_req_o, .rd_done_i, .wr_done_i, .rd_data_i
    );

    rv_decoder rv_decoder_inst (.instr_i(ir), .dec_o(dec));

    rv_regfile rv_regfile_inst (
        .clk, .reset, .rs1_i(dec.rs1), .rs2_i(dec.rs2),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(we), .rd_i(rd), .rd_data_i(rd_data)
    );

    rv_alu rv_alu_inst (
        .a_i(alu_a), .b_i(alu_b), .op_i(dec.alu_op), .word_i(dec.word),
        .branch_i(rv_isa_pkg::branch_e'(dec.funct3)), .result_o(alu_result), .taken_o(taken)
    );

endmodule

/* tests/rv64_program.svh */
`ifndef RV64_PROGRAM_SVH
`define RV64_PROGRAM_SVH

// Expected write table columns: address, ls_size_e, data
localparam int N_ALU = 24;                          // ALU results, one sd each at 0x1000 + 8k
localparam int N_EXP = 44;
localparam rv_bus_pkg::addr_t DATA_ADDR = 64'h2000;
localparam rv_isa_pkg::xlen_t DATA_WORD = 64'hFEDC_BA98_8765_C3A1;  // Top bits set in B, H, W

function automatic rv_isa_pkg::instr_t enc_r(int f7, int rs2, int rs1, int f3, int rd,
                                             logic [6:0] op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic rv_isa_pkg::instr_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic rv_isa_pkg::instr_t enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
endfunction

function automatic rv_isa_pkg::instr_t enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic rv_isa_pkg::instr_t enc_u(int imm, int rd, logic [6:0] op);
    return {imm[19:0], rd[4:0], op};
endfunction

function automatic rv_isa_pkg::instr_t enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

// x1 = 0x1000 store base, x2 = 0x2000 load base, x3 = -7, x4 = 0x123, x6 = 0x7FFFF000
task automatic load_program();
    rv_isa_pkg::instr_t alu [N_ALU];
    rv_isa_pkg::xlen_t  res [N_ALU];
    rv_isa_pkg::instr_t tail [51];
    wr_exp_t            other [20];
    int                 n;
    alu = '{enc_r(0, 4, 3, 0, 5, rv_isa_pkg::OPC_OP), enc_r('h20, 4, 3, 0, 5, rv_isa_pkg::OPC_OP),
        enc_r(0, 4, 3, 4, 5, rv_isa_pkg::OPC_OP), enc_r(0, 4, 3, 6, 5, rv_isa_pkg::OPC_OP),
        enc_r(0, 4, 3, 7, 5, rv_isa_pkg::OPC_OP), enc_r(0, 4, 3, 1, 5, rv_isa_pkg::OPC_OP),
        enc_r(0, 4, 3, 5, 5, rv_isa_pkg::OPC_OP), enc_r('h20, 4, 3, 5, 5, rv_isa_pkg::OPC_OP),
        enc_r(0, 4, 3, 2, 5, rv_isa_pkg::OPC_OP), enc_r(0, 4, 3, 3, 5, rv_isa_pkg::OPC_OP),
        enc_i(100, 3, 0, 5, rv_isa_pkg::OPC_OP_IMM), enc_i(-1, 4, 4, 5, rv_isa_pkg::OPC_OP_IMM),
        enc_i(40, 4, 1, 5, rv_isa_pkg::OPC_OP_IMM), enc_i('h401, 3, 5, 5, rv_isa_pkg::OPC_OP_IMM),
        enc_i(-8, 3, 2, 5, rv_isa_pkg::OPC_OP_IMM), enc_i(-1, 4, 3, 5, rv_isa_pkg::OPC_OP_IMM),
        enc_r(0, 6, 6, 0, 5, rv_isa_pkg::OPC_OP_32), enc_r('h20, 4, 3, 0, 5, rv_isa_pkg::OPC_OP_32),
        enc_r(0, 4, 6, 1, 5, rv_isa_pkg::OPC_OP_32), enc_r('h20, 4, 3, 5, 5, rv_isa_pkg::OPC_OP_32),
        enc_i('h7FF, 6, 0, 5, rv_isa_pkg::OPC_OP_IMM_32),
        enc_i(4, 3, 5, 5, rv_isa_pkg::OPC_OP_IMM_32),
        enc_u('h80000, 5, rv_isa_pkg::OPC_LUI), enc_u(1, 5, rv_isa_pkg::OPC_AUIPC)};
    res = '{64'h11C, 64'hFFFF_FFFF_FFFF_FED6, 64'hFFFF_FFFF_FFFF_FEDA, 64'hFFFF_FFFF_FFFF_FFFB,
        64'h121, 64'hFFFF_FFC8_0000_0000, 64'h1FFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 64'h0,
        64'h5D, 64'hFFFF_FFFF_FFFF_FEDC, 64'h0001_2300_0000_0000, 64'hFFFF_FFFF_FFFF_FFFC,
        64'h0, 64'h1, 64'hFFFF_FFFF_FFFF_E000, 64'hFFFF_FFFF_FFFF_FED6, 64'hFFFF_FFFF_FFFF_8000,
        64'hFFFF_FFFF_FFFF_FFFF, 64'h7FFF_F7FF, 64'h0FFF_FFFF, 64'hFFFF_FFFF_8000_0000,
        64'h8000_10CC};                     // AUIPC sits at 0x800000CC
    // Branch pairs: taken over a bad store, then not taken onto a good store
    tail = '{enc_b(8, 3, 3, 0), enc_s('h7F8, 0, 1, 3), enc_b(8, 4, 3, 0), enc_s('h100, 3, 1, 3),
        enc_b(8, 4, 3, 1), enc_s('h7F8, 0, 1, 3), enc_b(8, 4, 4, 1), enc_s('h108, 3, 1, 3),
        enc_b(8, 4, 3, 4), enc_s('h7F8, 0, 1, 3), enc_b(8, 3, 4, 4), enc_s('h110, 3, 1, 3),
        enc_b(8, 3, 4, 5), enc_s('h7F8, 0, 1, 3), enc_b(8, 4, 3, 5), enc_s('h118, 3, 1, 3),
        enc_b(8, 3, 4, 6), enc_s('h7F8, 0, 1, 3), enc_b(8, 4, 3, 6), enc_s('h120, 3, 1, 3),
        enc_b(8, 4, 3, 7), enc_s('h7F8, 0, 1, 3), enc_b(8, 3, 4, 7), enc_s('h128, 3, 1, 3),
        enc_j(8, 10), enc_s('h7F8, 0, 1, 3), enc_s('h140, 10, 1, 3),     // JAL at 0x80000134
        enc_u(0, 11, rv_isa_pkg::OPC_AUIPC), enc_i(13, 11, 0, 12, rv_isa_pkg::OPC_JALR),
        enc_s('h7F8, 0, 1, 3), enc_s('h148, 12, 1, 3),                     // JALR at 0x80000144
        enc_i(0, 2, 0, 5, rv_isa_pkg::OPC_LOAD), enc_s('h150, 5, 1, 3),
        enc_i(0, 2, 4, 5, rv_isa_pkg::OPC_LOAD), enc_s('h158, 5, 1, 3),
        enc_i(0, 2, 1, 5, rv_isa_pkg::OPC_LOAD), enc_s('h160, 5, 1, 3),
        enc_i(0, 2, 5, 5, rv_isa_pkg::OPC_LOAD), enc_s('h168, 5, 1, 3),
        enc_i(0, 2, 2, 5, rv_isa_pkg::OPC_LOAD), enc_s('h170, 5, 1, 3),
        enc_i(0, 2, 6, 5, rv_isa_pkg::OPC_LOAD), enc_s('h178, 5, 1, 3),
        enc_i(0, 2, 3, 5, rv_isa_pkg::OPC_LOAD), enc_s('h180, 5, 1, 3),
        enc_i(7, 2, 4, 5, rv_isa_pkg::OPC_LOAD), enc_s('h188, 5, 1, 3),
        enc_s('h190, 3, 1, 0), enc_s('h198, 3, 1, 1), enc_s('h1A0, 3, 1, 2), enc_s(-8, 4, 1, 2)};
    other = '{'{64'h1100, rv_bus_pkg::LS_D, 64'hFFFF_FFFF_FFFF_FFF9},
        '{64'h1108, rv_bus_pkg::LS_D, 64'hFFFF_FFFF_FFFF_FFF9},
        '{64'h1110, rv_bus_pkg::LS_D, 64'hFFFF_FFFF_FFFF_FFF9},
        '{64'h1118, rv_bus_pkg::LS_D, 64'hFFFF_FFFF_FFFF_FFF9},
        '{64'h1120, rv_bus_pkg::LS_D, 64'hFFFF_FFFF_FFFF_FFF9},
        '{64'h1128, rv_bus_pkg::LS_D, 64'hFFFF_FFFF_FFFF_FFF9},
        '{64'h1140, rv_bus_pkg::LS_D, 64'h8000_0138}, '{64'h1148, rv_bus_pkg::LS_D, 64'h8000_0148},
        '{64'h1150, rv_bus_pkg::LS_D, 64'hFFFF_FFFF_FFFF_FFA1},
        '{64'h1158, rv_bus_pkg::LS_D, 64'hA1},
        '{64'h1160, rv_bus_pkg::LS_D, 64'hFFFF_FFFF_FFFF_C3A1},
        '{64'h1168, rv_bus_pkg::LS_D, 64'hC3A1},
        '{64'h1170, rv_bus_pkg::LS_D, 64'hFFFF_FFFF_8765_C3A1},
        '{64'h1178, rv_bus_pkg::LS_D, 64'h8765_C3A1},
        '{64'h1180, rv_bus_pkg::LS_D, 64'hFEDC_BA98_8765_C3A1},
        '{64'h1188, rv_bus_pkg::LS_D, 64'hFE},
        '{64'h1190, rv_bus_pkg::LS_B, 64'hF9}, '{64'h1198, rv_bus_pkg::LS_H, 64'hFFF9},
        '{64'h11A0, rv_bus_pkg::LS_W, 64'hFFFF_FFF9}, '{64'h0FF8, rv_bus_pkg::LS_W, 64'h123}};
    foreach (rom[i]) begin
        rom[i] = 32'h0000_006F;             // jal x0, 0
    end
    rom[0] = enc_u(1, 1, rv_isa_pkg::OPC_LUI);
    rom[1] = enc_u(2, 2, rv_isa_pkg::OPC_LUI);
    rom[2] = enc_i(-7, 0, 0, 3, rv_isa_pkg::OPC_OP_IMM);
    rom[3] = enc_i('h123, 0, 0, 4, rv_isa_pkg::OPC_OP_IMM);
    rom[4] = enc_u('h7FFFF, 6, rv_isa_pkg::OPC_LUI);
    n = 5;
    for (int k = 0; k < N_ALU; k++) begin
        rom[n]     = alu[k];
        rom[n + 1] = enc_s(8 * k, 5, 1, 3);  // sd x5
        n += 2;
        exp_tbl[k] = '{64'h1000 + 64'(8 * k), rv_bus_pkg::LS_D, res[k]};
    end
    foreach (tail[j]) begin
        rom[n + j] = tail[j];
    end
    foreach (other[j]) begin
        exp_tbl[N_ALU + j] = other[j];
    end
endtask

`endif

/* tests/rv64_core_tb.sv */
module rv64_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        rv_bus_pkg::addr_t    addr;
        rv_bus_pkg::ls_size_e size;
        rv_isa_pkg::xlen_t    data;
    } wr_exp_t;

    logic                 clk;
    logic                 reset;
    rv_bus_pkg::addr_t    pc;
    rv_bus_pkg::addr_t    pc_off;
    rv_isa_pkg::instr_t   instr;
    rv_bus_pkg::bus_req_t bus_req;
    rv_bus_pkg::bus_req_t cur_req;     // Access being served
    rv_bus_pkg::addr_t    held_pc;
    logic                 rd_done;
    logic                 wr_done;
    rv_isa_pkg::xlen_t    rd_data;
    logic                 pending = 1'b0;
    logic [1:0]           delay;
    logic                 lat_bit;
    logic [31:0]          lfsr = 32'hedfc_c2d4;
    rv_isa_pkg::instr_t   rom [256];
    wr_exp_t              exp_tbl [64];

    `include "rv64_program.svh"

    rv64_core rv64_core_inst (
        .clk, .reset, .pc_o(pc), .instr_i(instr), .bus_req_o(bus_req),
        .rd_done_i(rd_done), .wr_done_i(wr_done), .rd_data_i(rd_data)
    );

    // Combinational instruction ROM, self-loop past the end
    assign pc_off = pc - rv_bus_pkg::RAM_BASE;
    assign instr  = (pc_off < 64'd1024) ? rom[pc_off[9:2]] : 32'h0000_006F;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    // Right-justified read, address-derived fill outside the data word
    function automatic rv_isa_pkg::xlen_t read_mem(input rv_bus_pkg::addr_t a);
        rv_isa_pkg::xlen_t d;
        if (a[63:3] == DATA_ADDR[63:3]) begin
            d = DATA_WORD;
        end else begin
            d = {a[31:0] ^ 32'h5A5A_5A5A, a[63:32]};
        end
        return d >> {a[2:0], 3'b000};
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (N_EXP * 40) @(posedge clk);     // About 40 cycles per expected write
        stop_run("Timeout: the program did not reach its last store");
    end

    // Memory agent, 0 to 3 extra cycles per access
    always @(posedge clk) begin
        if (reset) begin
            rd_done <= 1'b0;
            wr_done <= 1'b0;
            if (pending) begin
                assert (!(bus_req.rd || bus_req.wr))
                    else stop_run($sformatf("CHECK FAILED at %0t: second strobe while waiting", $time));
                assert (pc == held_pc)
                    else stop_run($sformatf("CHECK FAILED at %0t: pc_o moved to %h while waiting",
                                            $time, pc));
                if (delay == 2'd0) begin
                    pending <= 1'b0;
                    if (cur_req.rd) begin
                        rd_done <= 1'b1;
                        rd_data <= read_mem(cur_req.addr);
                    end else begin
                        wr_done <= 1'b1;
                    end
                end else begin
                    delay <= delay - 2'd1;
                end
            end else if (bus_req.rd || bus_req.wr) begin
                lat_bit = lfsr[0];      // One LFSR step per bit
                lfsr = lfsr_step(lfsr);
                delay   <= {lfsr[0], lat_bit};
                lfsr = lfsr_step(lfsr);
                cur_req <= bus_req;
                held_pc <= pc;
                pending <= 1'b1;
            end
        end
    end

    initial begin
        wr_exp_t e;
        reset   = 1'b0;
        rd_done = 1'b0;
        wr_done = 1'b0;
        rd_data = '0;
        load_program();
        repeat (4) begin
            @(negedge clk);             // Mid-cycle, reset has taken hold
            assert (pc == rv_bus_pkg::RAM_BASE && !bus_req.rd && !bus_req.wr)
                else stop_run($sformatf("CHECK FAILED at %0t: bad state in reset", $time));
        end
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);                 // First cycle out of reset
        assert (pc == rv_bus_pkg::RAM_BASE && !bus_req.rd && !bus_req.wr)
            else stop_run($sformatf("CHECK FAILED at %0t: bad state after reset", $time));
        // One table entry per write strobe
        for (int i = 0; i < N_EXP; i++) begin
            while (!bus_req.wr) begin
                @(posedge clk);
            end
            e = exp_tbl[i];
            assert (bus_req.addr == e.addr && bus_req.size == e.size && bus_req.wdata == e.data)
                else stop_run($sformatf({"CHECK FAILED at %0t: write %0d got %h/%0d/%h,",
                                         " expected %h/%0d/%h"}, $time, i, bus_req.addr,
                                        bus_req.size, bus_req.wdata, e.addr, e.size, e.data));
            @(posedge clk);
        end
        while (pending) begin           // Last store answered
            @(posedge clk);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

/* build.f */
+incdir+tests
hdl/rv_isa_pkg.sv
hdl/rv_bus_pkg.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_exec_ctrl.sv
hdl/rv64_core.sv
tests/rv64_core_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Mdir obj_dir
TOP       = rv64_core_tb
FILELIST  = build.f
PASS_MSG  = All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
